//--- sim/retire_tracer_tests.txt
# S dec(id_valid decoding illegal) exe(ex_valid bypass apu_en apu_rvalid) unit(single multi) wb_valid
#   pc instr compressed ex_we ex_addr ex_wdata wb_we wb_addr wb_wdata
# E pc instr compressed rd we wdata, in retire order
# ALU pair, then two loads (second writes a different register)
S 110 0000 00 0 00000080 00500093 0 0 0 00000000 0 0 00000000
S 110 1000 00 0 00000084 00108133 0 1 1 00000005 0 0 00000000
S 110 1000 00 1 00000088 00012183 0 1 2 0000000a 0 0 00000000
S 110 1000 00 1 0000008c 00412203 0 0 0 00000000 0 0 00000000
S 111 1000 00 1 deadbeef ffffffff 0 0 0 00000000 1 3 00001234
S 100 0000 00 1 0000cafe 00000013 0 0 0 00000000 1 5 00005555
# Long-latency APU divide held in EX-delay while two ALU ops finish
S 110 0000 00 0 00000090 0220c2b3 0 0 0 00000000 0 0 00000000
S 110 0010 00 0 00000094 00700313 0 0 0 00000000 0 0 00000000
S 110 1000 00 0 00000098 00800393 0 1 6 00000007 0 0 00000000
S 000 1000 00 1 00000000 00000000 0 1 7 00000008 0 0 00000000
S 000 0000 00 1 00000000 00000000 0 0 0 00000000 0 0 00000000
S 000 0000 00 0 00000000 00000000 0 0 0 00000000 0 0 00000000
S 000 0001 00 0 00000000 00000000 0 0 0 00000000 1 5 00000042
S 000 0000 00 1 00000000 00000000 0 0 0 00000000 0 0 00000000
# mret and c.ebreak, then a WB bypass between ordinary ops
S 110 0000 00 0 0000009c 30200073 0 0 0 00000000 0 0 00000000
S 110 1000 00 0 000000a0 00009002 1 0 0 00000000 0 0 00000000
S 000 1000 00 1 00000000 00000000 0 0 0 00000000 0 0 00000000
S 000 0000 00 1 00000000 00000000 0 0 0 00000000 0 0 00000000
S 110 0000 00 0 000000a2 00900413 0 0 0 00000000 0 0 00000000
S 110 1100 00 0 000000a6 00a00493 0 1 8 00000009 0 0 00000000
S 000 1000 00 0 00000000 00000000 0 1 9 0000000a 0 0 00000000
S 000 0000 00 1 00000000 00000000 0 0 0 00000000 0 0 00000000
E 00000080 00500093 0 1 1 00000005
E 00000084 00108133 0 2 1 0000000a
E 00000088 00012183 0 3 1 00001234
E 0000008c 00412203 0 4 0 00000000
E 00000090 0220c2b3 0 5 1 00000042
E 00000094 00700313 0 6 1 00000007
E 00000098 00800393 0 7 1 00000008
E 0000009c 30200073 0 0 0 00000000
E 000000a0 00009002 1 0 0 00000000
E 000000a2 00900413 0 8 1 00000009
E 000000a6 00a00493 0 9 1 0000000a

//--- vlog.f
verilog/trace_pkg.sv
verilog/trace_table.sv
verilog/stage_tracker.sv
verilog/reg_write_mapper.sv
verilog/retire_tracer.sv
sim/tb_retire_tracer.sv

//--- sim/tb_retire_tracer.sv
// ----------------------------------------
// Testbench for the retirement tracker, table depth 8
// Stimulus and expected records come from the tests file
// Run from the project root so the tests file path resolves
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_retire_tracer
  import trace_pkg::*;
();

  localparam int TABLE_DEPTH = 8;
  localparam int MAX_VEC     = 64;
  localparam int VEC_W       = 151;
  localparam int EXP_W       = 103;

  logic            clk_i;
  logic            rst_n;
  logic            id_valid_i, is_decoding_i, is_illegal_i, compressed_i;
  logic [XLEN-1:0] pc_i, instr_i;
  logic            ex_valid_i, wb_bypass_i, apu_en_i, apu_rvalid_i;
  logic            apu_singlecycle_i, apu_multicycle_i, wb_valid_i;
  logic            ex_reg_we_i, wb_reg_we_i;
  reg_addr_t       ex_reg_addr_i, wb_reg_addr_i;
  logic [XLEN-1:0] ex_reg_wdata_i, wb_reg_wdata_i;

  logic            retire_valid_o, retire_compressed_o, retire_we_o;
  logic [XLEN-1:0] retire_pc_o, retire_instr_o, retire_wdata_o;
  reg_addr_t       retire_rd_o;

  logic [VEC_W-1:0] vec_mem [MAX_VEC];
  logic [EXP_W-1:0] exp_mem [MAX_VEC];
  int               num_vec;
  int               num_exp;
  int               exp_idx;
  int               cycle_count;
  int               timeout_limit;

  retire_tracer #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) retire_tracer_i (
    .clk_i, .rst_n,
    .id_valid_i, .is_decoding_i, .is_illegal_i, .pc_i, .instr_i, .compressed_i,
    .ex_valid_i, .wb_bypass_i, .apu_en_i, .apu_rvalid_i,
    .apu_singlecycle_i, .apu_multicycle_i, .wb_valid_i,
    .ex_reg_we_i, .ex_reg_addr_i, .ex_reg_wdata_i,
    .wb_reg_we_i, .wb_reg_addr_i, .wb_reg_wdata_i,
    .retire_valid_o, .retire_pc_o, .retire_instr_o, .retire_compressed_o,
    .retire_rd_o, .retire_we_o, .retire_wdata_o
  );

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic string mismatch_text(input string field, input logic [XLEN-1:0] got,
                                          input logic [XLEN-1:0] want);
    return $sformatf("Fail at %0t: record %0d %s got %h expected %h",
                     $time, exp_idx, field, got, want);
  endfunction

  task automatic load_tests();
    int               fd;
    int               n;
    logic [63:0]      token;
    logic [8*256-1:0] rest_of_line;
    logic [2:0]       f_dec;
    logic [3:0]       f_exe;
    logic [1:0]       f_unit;
    logic             f_wb, f_c, f_exwe, f_wbwe, f_we;
    logic [31:0]      f_pc, f_instr, f_exdata, f_wbdata;
    logic [4:0]       f_exaddr, f_wbaddr;
    fd = $fopen("sim/retire_tracer_tests.txt", "r");
    assert (fd != 0) else abort_run("Could not open the tests file");
    n = $fscanf(fd, "%s", token);
    while (n == 1) begin
      assert (num_vec < MAX_VEC && num_exp < MAX_VEC)
        else abort_run("Tests file holds more lines than the testbench can store");
      if (token == "S") begin
        n = $fscanf(fd, "%b %b %b %b %h %h %b %b %d %h %b %d %h", f_dec, f_exe, f_unit,
                    f_wb, f_pc, f_instr, f_c, f_exwe, f_exaddr, f_exdata, f_wbwe,
                    f_wbaddr, f_wbdata);
        assert (n == 13) else abort_run("Stimulus line in the tests file is malformed");
        vec_mem[num_vec] = {f_dec, f_exe, f_unit, f_wb, f_pc, f_instr, f_c, f_exwe,
                            f_exaddr, f_exdata, f_wbwe, f_wbaddr, f_wbdata};
        num_vec++;
      end else if (token == "E") begin
        n = $fscanf(fd, "%h %h %b %d %b %h", f_pc, f_instr, f_c, f_exaddr, f_we, f_wbdata);
        assert (n == 6) else abort_run("Expected line in the tests file is malformed");
        exp_mem[num_exp] = {f_pc, f_instr, f_c, f_exaddr, f_we, f_wbdata};
        num_exp++;
      end else if (token == "#") begin
        n = $fgets(rest_of_line, fd);
      end else begin
        abort_run("Tests file has a line of unknown type");
      end
      n = $fscanf(fd, "%s", token);
    end
    $fclose(fd);
    assert (num_vec > 0 && num_exp > 0) else abort_run("Tests file has no stimulus or no records");
  endtask

  // Field order matches the S line columns
  task automatic drive_vector(input logic [VEC_W-1:0] vec);
    {id_valid_i, is_decoding_i, is_illegal_i, ex_valid_i, wb_bypass_i, apu_en_i,
     apu_rvalid_i, apu_singlecycle_i, apu_multicycle_i, wb_valid_i, pc_i, instr_i,
     compressed_i, ex_reg_we_i, ex_reg_addr_i, ex_reg_wdata_i, wb_reg_we_i,
     wb_reg_addr_i, wb_reg_wdata_i} = vec;
  endtask

  task automatic check_retire();
    logic [XLEN-1:0] e_pc, e_instr, e_wdata;
    logic            e_c, e_we;
    reg_addr_t       e_rd;
    assert (exp_idx < num_exp)
      else abort_run($sformatf("Fail at %0t: extra retire of pc %h", $time, retire_pc_o));
    {e_pc, e_instr, e_c, e_rd, e_we, e_wdata} = exp_mem[exp_idx];
    assert (retire_pc_o === e_pc) else abort_run(mismatch_text("pc", retire_pc_o, e_pc));
    assert (retire_instr_o === e_instr)
      else abort_run(mismatch_text("instr", retire_instr_o, e_instr));
    assert (retire_compressed_o === e_c)
      else abort_run(mismatch_text("compressed", retire_compressed_o, e_c));
    assert (retire_rd_o === e_rd) else abort_run(mismatch_text("rd", retire_rd_o, e_rd));
    assert (retire_we_o === e_we) else abort_run(mismatch_text("we", retire_we_o, e_we));
    // Value only means something with a write
    if (e_we) begin
      assert (retire_wdata_o === e_wdata)
        else abort_run(mismatch_text("wdata", retire_wdata_o, e_wdata));
    end
    exp_idx++;
  endtask

  // ----------------------------------------
  // Retire monitor and cycle limit
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (rst_n) begin
      cycle_count++;
      assert (cycle_count <= timeout_limit)
        else abort_run("Timeout: the retire stream did not complete in time");
      assert (!$isunknown(retire_valid_o))
        else abort_run("Retire valid is unknown after reset");
      if (retire_valid_o) begin
        check_retire();
      end
    end else begin
      assert (retire_valid_o !== 1'b1)
        else abort_run("A record retired while reset was asserted");
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_n       = 1'b0;
    num_vec     = 0;
    num_exp     = 0;
    exp_idx     = 0;
    cycle_count = 0;
    drive_vector('0);
    load_tests();
    timeout_limit = 2 * num_vec + 64;

    repeat (16) @(negedge clk_i);
    rst_n = 1'b1;
    for (int k = 0; k < num_vec; k++) begin
      drive_vector(vec_mem[k]);
      @(negedge clk_i);
    end
    drive_vector('0);

    while (exp_idx < num_exp) begin
      @(negedge clk_i);
    end
    // A few quiet cycles catch any record past the last one
    repeat (4) @(negedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/retire_tracer.sv
// ----------------------------------------
// Retirement tracker for the in-order core, records leave in decode order
// No back-pressure: the core must not run TABLE_DEPTH records ahead
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module retire_tracer
  import trace_pkg::*;
#(
  parameter int TABLE_DEPTH = 8
) (
  input  logic            clk_i,
  input  logic            rst_n,

  // Decode
  input  logic            id_valid_i,
  input  logic            is_decoding_i,
  input  logic            is_illegal_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic            compressed_i,

  // Execute
  input  logic            ex_valid_i,
  input  logic            wb_bypass_i,
  input  logic            apu_en_i,
  input  logic            apu_rvalid_i,
  input  logic            apu_singlecycle_i,
  input  logic            apu_multicycle_i,

  // Writeback
  input  logic            wb_valid_i,

  // Register write ports
  input  logic            ex_reg_we_i,
  input  reg_addr_t       ex_reg_addr_i,
  input  logic [XLEN-1:0] ex_reg_wdata_i,
  input  logic            wb_reg_we_i,
  input  reg_addr_t       wb_reg_addr_i,
  input  logic [XLEN-1:0] wb_reg_wdata_i,

  // Retire record
  output logic            retire_valid_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic [XLEN-1:0] retire_instr_o,
  output logic            retire_compressed_o,
  output reg_addr_t       retire_rd_o,
  output logic            retire_we_o,
  output logic [XLEN-1:0] retire_wdata_o
);

  localparam int TAG_W = $clog2(TABLE_DEPTH);

  logic                  alloc;
  logic [TAG_W-1:0]      alloc_tag;
  logic [1:0]            retire_mark;
  logic [1:0][TAG_W-1:0] retire_mark_tag;

  logic                  ex_valid_slot, ex_written, ex_written_stb;
  logic                  exd_valid_slot, exd_is_apu, exd_written, exd_written_stb;
  logic                  wb_valid_slot, wb_written, wb_written_stb;
  logic [TAG_W-1:0]      ex_tag, exd_tag, wb_tag;

  logic [1:0]            wr_en;
  logic [1:0][TAG_W-1:0] wr_tag;
  reg_addr_t [1:0]       wr_addr;
  logic [1:0][XLEN-1:0]  wr_data;

  stage_tracker #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) stage_tracker_i (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .id_valid_i        (id_valid_i),
    .is_decoding_i     (is_decoding_i),
    .is_illegal_i      (is_illegal_i),
    .instr_i           (instr_i),
    .compressed_i      (compressed_i),
    .ex_valid_i        (ex_valid_i),
    .wb_bypass_i       (wb_bypass_i),
    .apu_en_i          (apu_en_i),
    .apu_rvalid_i      (apu_rvalid_i),
    .wb_valid_i        (wb_valid_i),
    .alloc_tag_i       (alloc_tag),
    .ex_written_i      (ex_written_stb),
    .exd_written_i     (exd_written_stb),
    .wb_written_i      (wb_written_stb),
    .alloc_o           (alloc),
    .retire_mark_o     (retire_mark),
    .retire_mark_tag_o (retire_mark_tag),
    .ex_valid_slot_o   (ex_valid_slot),
    .ex_tag_o          (ex_tag),
    .ex_written_o      (ex_written),
    .exd_valid_slot_o  (exd_valid_slot),
    .exd_tag_o         (exd_tag),
    .exd_is_apu_o      (exd_is_apu),
    .exd_written_o     (exd_written),
    .wb_valid_slot_o   (wb_valid_slot),
    .wb_tag_o          (wb_tag),
    .wb_written_o      (wb_written)
  );

  reg_write_mapper #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) reg_write_mapper_i (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .ex_reg_we_i       (ex_reg_we_i),
    .ex_reg_addr_i     (ex_reg_addr_i),
    .ex_reg_wdata_i    (ex_reg_wdata_i),
    .wb_reg_we_i       (wb_reg_we_i),
    .wb_reg_addr_i     (wb_reg_addr_i),
    .wb_reg_wdata_i    (wb_reg_wdata_i),
    .ex_valid_i        (ex_valid_i),
    .apu_rvalid_i      (apu_rvalid_i),
    .apu_singlecycle_i (apu_singlecycle_i),
    .apu_multicycle_i  (apu_multicycle_i),
    .ex_valid_slot_i   (ex_valid_slot),
    .ex_tag_i          (ex_tag),
    .ex_written_i      (ex_written),
    .exd_valid_slot_i  (exd_valid_slot),
    .exd_tag_i         (exd_tag),
    .exd_is_apu_i      (exd_is_apu),
    .exd_written_i     (exd_written),
    .wb_valid_slot_i   (wb_valid_slot),
    .wb_tag_i          (wb_tag),
    .wb_written_i      (wb_written),
    .wr_en_o           (wr_en),
    .wr_tag_o          (wr_tag),
    .wr_addr_o         (wr_addr),
    .wr_data_o         (wr_data),
    .ex_written_o      (ex_written_stb),
    .exd_written_o     (exd_written_stb),
    .wb_written_o      (wb_written_stb)
  );

  trace_table #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) trace_table_i (
    .clk_i               (clk_i),
    .rst_n               (rst_n),
    .alloc_i             (alloc),
    .pc_i                (pc_i),
    .instr_i             (instr_i),
    .compressed_i        (compressed_i),
    .alloc_tag_o         (alloc_tag),
    .retire_mark_i       (retire_mark),
    .retire_mark_tag_i   (retire_mark_tag),
    .wr_en_i             (wr_en),
    .wr_tag_i            (wr_tag),
    .wr_addr_i           (wr_addr),
    .wr_data_i           (wr_data),
    .retire_valid_o      (retire_valid_o),
    .retire_pc_o         (retire_pc_o),
    .retire_instr_o      (retire_instr_o),
    .retire_compressed_o (retire_compressed_o),
    .retire_rd_o         (retire_rd_o),
    .retire_we_o         (retire_we_o),
    .retire_wdata_o      (retire_wdata_o)
  );

endmodule

`default_nettype wire

//--- verilog/reg_write_mapper.sv
// ----------------------------------------
// Routes EX-port and WB-port register writes to a pipeline slot
// Chosen writes reach the table one cycle later, one lane per port
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_write_mapper
  import trace_pkg::*;
#(
  parameter  int TABLE_DEPTH = 8,
  localparam int TAG_W       = $clog2(TABLE_DEPTH)
) (
  input  logic                  clk_i,
  input  logic                  rst_n,

  input  logic                  ex_reg_we_i,
  input  reg_addr_t             ex_reg_addr_i,
  input  logic [XLEN-1:0]       ex_reg_wdata_i,
  input  logic                  wb_reg_we_i,
  input  reg_addr_t             wb_reg_addr_i,
  input  logic [XLEN-1:0]       wb_reg_wdata_i,
  input  logic                  ex_valid_i,
  input  logic                  apu_rvalid_i,
  input  logic                  apu_singlecycle_i,
  input  logic                  apu_multicycle_i,

  input  logic                  ex_valid_slot_i,
  input  logic [TAG_W-1:0]      ex_tag_i,
  input  logic                  ex_written_i,
  input  logic                  exd_valid_slot_i,
  input  logic [TAG_W-1:0]      exd_tag_i,
  input  logic                  exd_is_apu_i,
  input  logic                  exd_written_i,
  input  logic                  wb_valid_slot_i,
  input  logic [TAG_W-1:0]      wb_tag_i,
  input  logic                  wb_written_i,

  output logic [1:0]            wr_en_o,
  output logic [1:0][TAG_W-1:0] wr_tag_o,
  output reg_addr_t [1:0]       wr_addr_o,
  output logic [1:0][XLEN-1:0]  wr_data_o,
  output logic                  ex_written_o,
  output logic                  exd_written_o,
  output logic                  wb_written_o
);

  logic ex_fire;
  logic ex_to_exd, ex_to_ex;
  logic wb_to_exd, wb_to_wb;
  logic apu_short;

  assign apu_short = apu_singlecycle_i || apu_multicycle_i;
  assign ex_fire   = ex_reg_we_i && (ex_valid_i || apu_rvalid_i);

  // EX port: older EX-delay entry first, else the EX slot
  assign ex_to_exd = ex_fire && exd_valid_slot_i && !exd_written_i &&
                     ((!exd_is_apu_i && ex_valid_i) ||
                      (exd_is_apu_i && apu_rvalid_i && apu_short));
  assign ex_to_ex  = ex_fire && !ex_to_exd && ex_valid_slot_i && !ex_written_i;

  // WB port: long-latency APU result, else the WB slot
  assign wb_to_exd = wb_reg_we_i && exd_valid_slot_i && exd_is_apu_i &&
                     apu_rvalid_i && !apu_short;
  assign wb_to_wb  = wb_reg_we_i && !wb_to_exd && wb_valid_slot_i && !wb_written_i;

  assign ex_written_o  = ex_to_ex;
  assign exd_written_o = ex_to_exd || wb_to_exd;
  assign wb_written_o  = wb_to_wb;

  // ----------------------------------------
  // Registered writes toward the table
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_o <= '0;
    end else begin
      wr_en_o[0] <= ex_to_exd || ex_to_ex;
      wr_en_o[1] <= wb_to_exd || wb_to_wb;
    end
  end

  always_ff @(posedge clk_i) begin
    wr_tag_o[0]  <= ex_to_exd ? exd_tag_i : ex_tag_i;
    wr_addr_o[0] <= ex_reg_addr_i;
    wr_data_o[0] <= ex_reg_wdata_i;
    wr_tag_o[1]  <= wb_to_exd ? exd_tag_i : wb_tag_i;
    wr_addr_o[1] <= wb_reg_addr_i;
    wr_data_o[1] <= wb_reg_wdata_i;
  end

  // An EX write with no slot to take it means the slot model lost sync
  assert property (@(posedge clk_i) disable iff (!rst_n)
    ex_fire |-> (ex_to_exd || ex_to_ex))
    else $error("EX register write with no active instruction");

endmodule

`default_nettype wire

//--- verilog/stage_tracker.sv
// ----------------------------------------
// EX, EX-delay, WB and WB-delay slots of the traced pipeline
// EX and EX-delay are overwritten when entered while occupied, as in the core
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stage_tracker
  import trace_pkg::*;
#(
  parameter  int TABLE_DEPTH = 8,
  localparam int TAG_W       = $clog2(TABLE_DEPTH)
) (
  input  logic                  clk_i,
  input  logic                  rst_n,

  input  logic                  id_valid_i,
  input  logic                  is_decoding_i,
  input  logic                  is_illegal_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic                  compressed_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_bypass_i,
  input  logic                  apu_en_i,
  input  logic                  apu_rvalid_i,
  input  logic                  wb_valid_i,

  input  logic [TAG_W-1:0]      alloc_tag_i,
  input  logic                  ex_written_i,
  input  logic                  exd_written_i,
  input  logic                  wb_written_i,

  output logic                  alloc_o,
  output logic [1:0]            retire_mark_o,
  output logic [1:0][TAG_W-1:0] retire_mark_tag_o,

  output logic                  ex_valid_slot_o,
  output logic [TAG_W-1:0]      ex_tag_o,
  output logic                  ex_written_o,
  output logic                  exd_valid_slot_o,
  output logic [TAG_W-1:0]      exd_tag_o,
  output logic                  exd_is_apu_o,
  output logic                  exd_written_o,
  output logic                  wb_valid_slot_o,
  output logic [TAG_W-1:0]      wb_tag_o,
  output logic                  wb_written_o
);

  logic             ex_valid_q, ex_written_q, ex_delay_q;
  logic             exd_valid_q, exd_written_q, exd_delay_q, exd_is_apu_q;
  logic             wb_valid_q, wb_written_q, wb_delay_q;
  logic             wbd_valid_q;
  logic [TAG_W-1:0] ex_tag_q, exd_tag_q, wb_tag_q, wbd_tag_q;

  instr_word_u      dec_word;
  logic             new_instr;
  logic             new_is_delay;
  logic             ex_bypass, ex_to_exd, ex_to_wb, ex_apu;
  logic             exd_to_wb, wb_leave, wb_to_wbd;

  // Delay instructions are recognised once, at decode
  assign dec_word     = instr_i;
  assign new_is_delay = (dec_word.raw == INSTR_MRET) || (dec_word.raw == INSTR_URET) ||
                        (dec_word.raw == INSTR_EBREAK) ||
                        (compressed_i && (dec_word.raw[15:0] == INSTR_C_EBREAK));
  assign new_instr    = id_valid_i && is_decoding_i && !is_illegal_i;
  assign alloc_o      = new_instr;

  // ----------------------------------------
  // Movement decisions
  // ----------------------------------------
  assign wb_leave  = wb_valid_q && wb_valid_i;
  assign wb_to_wbd = wb_leave && wb_delay_q;
  // Non-APU entries pass through EX-delay in one cycle
  assign exd_to_wb = exd_valid_q && (apu_rvalid_i || !exd_is_apu_q);

  always_comb begin
    ex_bypass = 1'b0;
    ex_to_exd = 1'b0;
    ex_to_wb  = 1'b0;
    ex_apu    = 1'b0;
    if (ex_valid_q) begin
      if (wb_bypass_i) begin
        ex_bypass = 1'b1;
      end else if (apu_en_i && !apu_rvalid_i) begin
        ex_to_exd = 1'b1;
        ex_apu    = 1'b1;
      end else if (ex_valid_i) begin
        // EX-delay takes WB this cycle so EX waits one slot behind it
        if (exd_to_wb) begin
          ex_to_exd = 1'b1;
        end else begin
          ex_to_wb = 1'b1;
        end
      end
    end
  end

  // WB-delay and a bypass never coincide in the core and share mark 1
  assign retire_mark_o[0]     = wb_leave && !wb_delay_q;
  assign retire_mark_tag_o[0] = wb_tag_q;
  assign retire_mark_o[1]     = wbd_valid_q || ex_bypass;
  assign retire_mark_tag_o[1] = wbd_valid_q ? wbd_tag_q : ex_tag_q;

  // ----------------------------------------
  // Slot registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_q    <= 1'b0;
      ex_written_q  <= 1'b0;
      ex_delay_q    <= 1'b0;
      exd_valid_q   <= 1'b0;
      exd_written_q <= 1'b0;
      exd_delay_q   <= 1'b0;
      exd_is_apu_q  <= 1'b0;
      wb_valid_q    <= 1'b0;
      wb_written_q  <= 1'b0;
      wb_delay_q    <= 1'b0;
      wbd_valid_q   <= 1'b0;
    end else begin
      // EX
      if (new_instr) begin
        ex_valid_q   <= 1'b1;
        ex_written_q <= 1'b0;
        ex_delay_q   <= new_is_delay;
      end else if (ex_bypass || ex_to_exd || ex_to_wb) begin
        ex_valid_q   <= 1'b0;
        ex_written_q <= 1'b0;
      end else begin
        ex_written_q <= ex_written_q || ex_written_i;
      end

      // EX-delay
      if (ex_to_exd) begin
        exd_valid_q   <= 1'b1;
        exd_written_q <= ex_written_q || ex_written_i;
        exd_delay_q   <= ex_delay_q;
        exd_is_apu_q  <= ex_apu;
      end else if (exd_to_wb) begin
        exd_valid_q   <= 1'b0;
        exd_written_q <= 1'b0;
      end else begin
        exd_written_q <= exd_written_q || exd_written_i;
      end

      // WB
      if (ex_to_wb) begin
        wb_valid_q   <= 1'b1;
        wb_written_q <= ex_written_q || ex_written_i;
        wb_delay_q   <= ex_delay_q;
      end else if (exd_to_wb) begin
        wb_valid_q   <= 1'b1;
        wb_written_q <= exd_written_q || exd_written_i;
        wb_delay_q   <= exd_delay_q;
      end else if (wb_leave) begin
        wb_valid_q   <= 1'b0;
        wb_written_q <= 1'b0;
      end else begin
        wb_written_q <= wb_written_q || wb_written_i;
      end

      // WB-delay holds for exactly one cycle
      wbd_valid_q <= wb_to_wbd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (new_instr) begin
      ex_tag_q <= alloc_tag_i;
    end
    if (ex_to_exd) begin
      exd_tag_q <= ex_tag_q;
    end
    if (ex_to_wb) begin
      wb_tag_q <= ex_tag_q;
    end else if (exd_to_wb) begin
      wb_tag_q <= exd_tag_q;
    end
    if (wb_to_wbd) begin
      wbd_tag_q <= wb_tag_q;
    end
  end

  assign ex_valid_slot_o  = ex_valid_q;
  assign ex_tag_o         = ex_tag_q;
  assign ex_written_o     = ex_written_q;
  assign exd_valid_slot_o = exd_valid_q;
  assign exd_tag_o        = exd_tag_q;
  assign exd_is_apu_o     = exd_is_apu_q;
  assign exd_written_o    = exd_written_q;
  assign wb_valid_slot_o  = wb_valid_q;
  assign wb_tag_o         = wb_tag_q;
  assign wb_written_o     = wb_written_q;

  // A record moving into WB never lands on one that stays there
  assert property (@(posedge clk_i) disable iff (!rst_n)
    (ex_to_wb || exd_to_wb) |-> (!wb_valid_q || wb_leave))
    else $error("record entering WB collides with one still held there");

endmodule

`default_nettype wire

//--- verilog/trace_table.sv
// ----------------------------------------
// Circular record store, one entry per decoded instruction
// TABLE_DEPTH must be a power of two; no back-pressure on allocation
// Retire outputs read the head entry and see a same-cycle write
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module trace_table
  import trace_pkg::*;
#(
  parameter  int TABLE_DEPTH = 8,
  localparam int TAG_W       = $clog2(TABLE_DEPTH)
) (
  input  logic                       clk_i,
  input  logic                       rst_n,

  input  logic                       alloc_i,
  input  logic [XLEN-1:0]            pc_i,
  input  logic [XLEN-1:0]            instr_i,
  input  logic                       compressed_i,
  output logic [TAG_W-1:0]           alloc_tag_o,

  input  logic [1:0]                 retire_mark_i,
  input  logic [1:0][TAG_W-1:0]      retire_mark_tag_i,

  input  logic [1:0]                 wr_en_i,
  input  logic [1:0][TAG_W-1:0]      wr_tag_i,
  input  reg_addr_t [1:0]            wr_addr_i,
  input  logic [1:0][XLEN-1:0]       wr_data_i,

  output logic                       retire_valid_o,
  output logic [XLEN-1:0]            retire_pc_o,
  output logic [XLEN-1:0]            retire_instr_o,
  output logic                       retire_compressed_o,
  output reg_addr_t                  retire_rd_o,
  output logic                       retire_we_o,
  output logic [XLEN-1:0]            retire_wdata_o
);

  logic [XLEN-1:0]        pc_mem    [TABLE_DEPTH];
  logic [XLEN-1:0]        instr_mem [TABLE_DEPTH];
  logic                   comp_mem  [TABLE_DEPTH];
  reg_addr_t              rd_mem    [TABLE_DEPTH];
  logic [XLEN-1:0]        wdata_mem [TABLE_DEPTH];

  logic [TABLE_DEPTH-1:0] busy_q;
  logic [TABLE_DEPTH-1:0] done_q;
  logic [TABLE_DEPTH-1:0] we_q;
  logic [TAG_W-1:0]       head_q;
  logic [TAG_W-1:0]       tail_q;

  instr_word_u            alloc_word;
  logic [1:0]             wr_hit;
  logic [1:0]             head_hit;

  assign alloc_word  = instr_i;
  assign alloc_tag_o = tail_q;

  // A write lands only on a live record whose rd matches
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      wr_hit[k]   = wr_en_i[k] && busy_q[wr_tag_i[k]] &&
                    (wr_addr_i[k] == rd_mem[wr_tag_i[k]]);
      head_hit[k] = wr_hit[k] && (wr_tag_i[k] == head_q);
    end
  end

  // ----------------------------------------
  // Head record and retire pulse
  // ----------------------------------------
  assign retire_valid_o      = busy_q[head_q] && done_q[head_q];
  assign retire_pc_o         = pc_mem[head_q];
  assign retire_instr_o      = instr_mem[head_q];
  assign retire_compressed_o = comp_mem[head_q];
  assign retire_rd_o         = rd_mem[head_q];

  // Port 1 (WB side) wins when both hit the head
  always_comb begin
    retire_we_o    = we_q[head_q];
    retire_wdata_o = wdata_mem[head_q];
    for (int k = 0; k < 2; k++) begin
      if (head_hit[k]) begin
        retire_we_o    = 1'b1;
        retire_wdata_o = wr_data_i[k];
      end
    end
  end

  // ----------------------------------------
  // Entry state and pointers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
      done_q <= '0;
      we_q   <= '0;
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (retire_valid_o) begin
        busy_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (alloc_i) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        we_q[tail_q]   <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      for (int k = 0; k < 2; k++) begin
        if (retire_mark_i[k]) begin
          done_q[retire_mark_tag_i[k]] <= 1'b1;
        end
        if (wr_hit[k]) begin
          we_q[wr_tag_i[k]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      pc_mem[tail_q]    <= pc_i;
      instr_mem[tail_q] <= instr_i;
      comp_mem[tail_q]  <= compressed_i;
      rd_mem[tail_q]    <= alloc_word.fields.rd;
    end
    for (int k = 0; k < 2; k++) begin
      if (wr_hit[k]) begin
        wdata_mem[wr_tag_i[k]] <= wr_data_i[k];
      end
    end
  end

  // Table full means an in-flight record would be overwritten
  assert property (@(posedge clk_i) disable iff (!rst_n)
    alloc_i |-> !busy_q[tail_q])
    else $error("record table overflow");

  // Marks come from pipeline slots, which always hold live records
  assert property (@(posedge clk_i) disable iff (!rst_n)
    (!retire_mark_i[0] || busy_q[retire_mark_tag_i[0]]) &&
    (!retire_mark_i[1] || busy_q[retire_mark_tag_i[1]]))
    else $error("retire mark on a free record");

endmodule

`default_nettype wire

//--- verilog/trace_pkg.sv
// ----------------------------------------
// Widths and constant encodings shared by the retirement tracker
// Integer registers only, with no FP register tracking
// ----------------------------------------
`default_nettype none

package trace_pkg;

  // Data and pc width
  localparam int XLEN = 32;

  // Integer register address
  typedef logic [4:0] reg_addr_t;

  // R-type field split of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_fields_t;

  // Raw view for exact matches, field view for rd extraction
  typedef union packed {
    logic [31:0]   raw;
    instr_fields_t fields;
  } instr_word_u;

  // ----------------------------------------
  // Instructions that retire one cycle late
  // ----------------------------------------
  localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
  localparam logic [31:0] INSTR_URET   = 32'h0020_0073;
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

  // Compressed form, checked on the low half only
  localparam logic [15:0] INSTR_C_EBREAK = 16'h9002;

endpackage

`default_nettype wire
